//--- sim.f
verilog/mips_isa_pkg.sv
verilog/mips_ctrl_pkg.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_datapath.sv
verilog/mips_control.sv
verilog/mips_cpu.sv
testbench/tb_mips_cpu.sv

//--- testbench/mips_testdata.txt
// Word 0 is the program length in words, then the program from address 0
// Then the store count, then one store per line: test id, address, data
0000002e
3c011234 34215678 24028f0f 00221821 // lui, ori, addiu, addu
00222023 00222824 00223025 00223826 // subu, and, or, xor
0041402a 0022482a 00015100 00025a02 // slt both ways, sll, srl
ac030200 ac040204 ac050208 ac06020c // store the ALU results
ac070210 ac080214 ac090218 ac0a021c
ac0b0220 8c0c0200 258c0001 ac0c0224 // reload, add one, store again
24000005 ac000228 11090001 ac080230 // write $zero, beq not taken
10210001 ac080234 14220001 ac080238 // beq and bne taken over markers
14210001 ac09023c 08000024 ac080240 // bne not taken, j over marker
0c00002d ac1f0244 240effff 01c10019 // jal then store $ra, multu
00007810 00008012 ac0f0248 ac10024c // mfhi, mflo and their stores
1000ffff 03e00008                   // halt loop, subroutine jr $ra
00000010
1 00000200 1233e587
1 00000204 1234c769
1 00000208 12340608
1 0000020c ffffdf7f
1 00000210 edcbd977
1 00000214 00000001
1 00000218 00000000
1 0000021c 23456780
1 00000220 00ffff8f
2 00000224 1233e588
2 00000228 00000000
3 00000230 00000001
3 0000023c 00000000
4 00000244 00000094
5 00000248 12345677
5 0000024c edcba988

//--- testbench/tb_mips_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mips_cpu;

    localparam int W             = mips_isa_pkg::WORD_W;
    localparam int MEM_WORDS     = 256;
    localparam int TD_WORDS      = 96; // Length, program, store count, store triples
    localparam int STORE_TIMEOUT = 200; // Cycles allowed between two stores
    localparam logic [W-1:0] RESET_PC = '0;

    logic         clk;
    logic         reset;
    logic [W-1:0] mem_addr;
    logic [W-1:0] mem_wdata;
    logic [W-1:0] mem_rdata;
    logic         mem_read;
    logic         mem_write;

    logic [W-1:0] mem [MEM_WORDS];
    logic [W-1:0] testdata [TD_WORDS];
    logic [W-1:0] exp_id [$];
    logic [W-1:0] exp_addr [$];
    logic [W-1:0] exp_data [$];

    mips_cpu #(
        .RESET_PC(RESET_PC)
    ) UUT (
        .clk(clk),
        .reset(reset),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_read(mem_read),
        .mem_write(mem_write)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Word addressed, no wait states, data only while the read strobe is high
    assign mem_rdata = mem_read ? mem[mem_addr[9:2]] : 'x;

    always @(posedge clk) begin
        if (mem_write === 1'b1) begin
            mem[mem_addr[9:2]] <= mem_wdata;
        end
    end

    function automatic string test_name(input logic [W-1:0] id);
        case (id)
            1: return "alu";
            2: return "load";
            3: return "branch";
            4: return "jump";
            5: return "multu";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [W-1:0] expected,
                               input logic [W-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic wait_for_store(input int index);
        for (int cycles = 0; cycles < STORE_TIMEOUT; cycles++) begin
            @(posedge clk);
            if (mem_write === 1'b1) begin
                return; // Bus values still hold the store of this edge
            end
        end
        $display("Store %0d was expected but never occurred within %0d cycles",
                 index, STORE_TIMEOUT);
        $display("Simulation failed");
        $fatal(1, "Timed out waiting for a memory write");
    endtask

    initial begin
        int    prog_words;
        int    store_count;
        int    pos;
        string name;
        reset = 1'b1;
        $readmemh("testbench/mips_testdata.txt", testdata);
        if ($isunknown(testdata[0])) begin
            $display("The test data file could not be read");
            $display("Simulation failed");
            $fatal(1, "No program loaded");
        end
        prog_words = testdata[0];
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < prog_words) begin
                mem[i] = testdata[1 + i];
            end else begin
                mem[i] = 32'hbad0_0000 | W'(i); // Unused words trap stray fetches
            end
        end
        pos = prog_words + 1;
        store_count = testdata[pos];
        for (int i = 0; i < store_count; i++) begin
            exp_id.push_back(testdata[pos + 1 + 3 * i]);
            exp_addr.push_back(testdata[pos + 2 + 3 * i]);
            exp_data.push_back(testdata[pos + 3 + 3 * i]);
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk); // First FETCH after reset reads the reset PC
        check_value("reset fetch read", W'(1), W'(mem_read));
        check_value("reset fetch address", RESET_PC, mem_addr);
        while (exp_addr.size() > 0) begin
            wait_for_store(store_count - exp_addr.size());
            name = test_name(exp_id.pop_front());
            check_value({name, " address"}, exp_addr.pop_front(), mem_addr);
            check_value({name, " data"}, exp_data.pop_front(), mem_wdata);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mips_alu.sv
`timescale 1ns/1ns
`default_nettype none

module mips_alu (
    input  logic [mips_isa_pkg::WORD_W-1:0]  a,
    input  logic [mips_isa_pkg::WORD_W-1:0]  b,
    input  logic [mips_isa_pkg::SHAMT_W-1:0] shamt,
    input  mips_ctrl_pkg::alu_op_t           op,
    output logic [mips_isa_pkg::WORD_W-1:0]  result,
    output logic [mips_isa_pkg::WORD_W-1:0]  hi_result,
    output logic                             zero
);

    localparam int W = mips_isa_pkg::WORD_W;
    localparam int IMM_W = mips_isa_pkg::IMM_W;

    logic [2*W-1:0] product;

    assign product   = a * b; // Unsigned 64-bit product
    assign hi_result = product[2*W-1:W];

    always_comb begin
        case (op)
            mips_ctrl_pkg::ALU_ADD:    result = a + b;
            mips_ctrl_pkg::ALU_SUB:    result = a - b;
            mips_ctrl_pkg::ALU_AND:    result = a & b;
            mips_ctrl_pkg::ALU_OR:     result = a | b;
            mips_ctrl_pkg::ALU_XOR:    result = a ^ b;
            mips_ctrl_pkg::ALU_SLT:    result = {{(W-1){1'b0}}, $signed(a) < $signed(b)};
            mips_ctrl_pkg::ALU_SLL:    result = b << shamt;
            mips_ctrl_pkg::ALU_SRL:    result = b >> shamt;
            mips_ctrl_pkg::ALU_LUI:    result = {b[IMM_W-1:0], {(W-IMM_W){1'b0}}};
            mips_ctrl_pkg::ALU_PASS_B: result = b;
            mips_ctrl_pkg::ALU_MULTU:  result = product[W-1:0]; // Low word for LO
            mips_ctrl_pkg::ALU_EQ,
            mips_ctrl_pkg::ALU_NE:     result = a - b;
            default:                   result = '0;
        endcase
    end

    always_comb begin
        case (op)
            mips_ctrl_pkg::ALU_EQ: zero = (a == b); // Branch condition
            mips_ctrl_pkg::ALU_NE: zero = (a != b);
            default:               zero = (result == '0);
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mips_control.sv
`timescale 1ns/1ns
`default_nettype none

module mips_control (
    input  logic                     clk,
    input  logic                     reset,
    input  mips_isa_pkg::opcode_t    op,
    input  mips_isa_pkg::funct_t     funct,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic                     ir_write,
    output logic                     iord,
    output logic                     pc_write,
    output logic                     pc_write_cond,
    output logic                     reg_write,
    output logic                     hilo_write,
    output logic                     alu_src_a,
    output mips_ctrl_pkg::src_b_t    alu_src_b,
    output mips_ctrl_pkg::alu_op_t   alu_op,
    output mips_ctrl_pkg::pc_src_t   pc_src,
    output mips_ctrl_pkg::wb_sel_t   wb_sel,
    output mips_ctrl_pkg::dest_sel_t dest_sel
);

    mips_ctrl_pkg::state_t state;
    mips_ctrl_pkg::state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_ctrl_pkg::FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            mips_ctrl_pkg::FETCH:  next_state = mips_ctrl_pkg::DECODE;
            mips_ctrl_pkg::DECODE: next_state = mips_ctrl_pkg::EXECUTE;
            mips_ctrl_pkg::EXECUTE: begin
                if (op == mips_isa_pkg::OP_LW || op == mips_isa_pkg::OP_JAL) begin
                    next_state = mips_ctrl_pkg::WRITEBACK; // Extra cycle for load data or link
                end else begin
                    next_state = mips_ctrl_pkg::FETCH;
                end
            end
            default: next_state = mips_ctrl_pkg::FETCH;
        endcase
    end

    always_comb begin
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        ir_write      = 1'b0;
        iord          = 1'b0; // Address from PC
        pc_write      = 1'b0;
        pc_write_cond = 1'b0;
        reg_write     = 1'b0;
        hilo_write    = 1'b0;
        alu_src_a     = 1'b0; // Operand A from PC
        alu_src_b     = mips_ctrl_pkg::SRC_B_REG;
        alu_op        = mips_ctrl_pkg::ALU_ADD;
        pc_src        = mips_ctrl_pkg::PC_SRC_ALU;
        wb_sel        = mips_ctrl_pkg::WB_ALU_OUT;
        dest_sel      = mips_ctrl_pkg::DEST_RT;
        case (state)
            mips_ctrl_pkg::FETCH: begin
                mem_read  = 1'b1;
                ir_write  = 1'b1;
                alu_src_b = mips_ctrl_pkg::SRC_B_FOUR; // PC + 4
                pc_write  = !reset; // PC stays at RESET_PC until reset drops
            end
            mips_ctrl_pkg::DECODE: begin
                alu_src_b = mips_ctrl_pkg::SRC_B_BRANCH; // Branch target into ALU-out
            end
            mips_ctrl_pkg::EXECUTE: begin
                alu_src_a = 1'b1;
                case (op)
                    mips_isa_pkg::OP_RTYPE: begin
                        dest_sel  = mips_ctrl_pkg::DEST_RD;
                        reg_write = 1'b1;
                        case (funct)
                            mips_isa_pkg::FN_ADDU: alu_op = mips_ctrl_pkg::ALU_ADD;
                            mips_isa_pkg::FN_SUBU: alu_op = mips_ctrl_pkg::ALU_SUB;
                            mips_isa_pkg::FN_AND:  alu_op = mips_ctrl_pkg::ALU_AND;
                            mips_isa_pkg::FN_OR:   alu_op = mips_ctrl_pkg::ALU_OR;
                            mips_isa_pkg::FN_XOR:  alu_op = mips_ctrl_pkg::ALU_XOR;
                            mips_isa_pkg::FN_SLT:  alu_op = mips_ctrl_pkg::ALU_SLT;
                            mips_isa_pkg::FN_SLL:  alu_op = mips_ctrl_pkg::ALU_SLL;
                            mips_isa_pkg::FN_SRL:  alu_op = mips_ctrl_pkg::ALU_SRL;
                            mips_isa_pkg::FN_MFHI: wb_sel = mips_ctrl_pkg::WB_HI;
                            mips_isa_pkg::FN_MFLO: wb_sel = mips_ctrl_pkg::WB_LO;
                            mips_isa_pkg::FN_JR: begin
                                reg_write = 1'b0;
                                alu_op    = mips_ctrl_pkg::ALU_PASS_B;
                                pc_src    = mips_ctrl_pkg::PC_SRC_REG_A;
                                pc_write  = 1'b1;
                            end
                            mips_isa_pkg::FN_MULTU: begin
                                reg_write  = 1'b0;
                                alu_op     = mips_ctrl_pkg::ALU_MULTU;
                                hilo_write = 1'b1;
                            end
                            default: reg_write = 1'b0; // Unsupported funct is a no-op
                        endcase
                    end
                    mips_isa_pkg::OP_ADDIU: begin
                        alu_src_b = mips_ctrl_pkg::SRC_B_SIMM;
                        reg_write = 1'b1;
                    end
                    mips_isa_pkg::OP_ORI: begin
                        alu_src_b = mips_ctrl_pkg::SRC_B_ZIMM;
                        alu_op    = mips_ctrl_pkg::ALU_OR;
                        reg_write = 1'b1;
                    end
                    mips_isa_pkg::OP_LUI: begin
                        alu_src_b = mips_ctrl_pkg::SRC_B_ZIMM;
                        alu_op    = mips_ctrl_pkg::ALU_LUI;
                        reg_write = 1'b1;
                    end
                    mips_isa_pkg::OP_LW: begin
                        alu_src_b = mips_ctrl_pkg::SRC_B_SIMM;
                        mem_read  = 1'b1;
                        iord      = 1'b1;
                    end
                    mips_isa_pkg::OP_SW: begin
                        alu_src_b = mips_ctrl_pkg::SRC_B_SIMM;
                        mem_write = 1'b1;
                        iord      = 1'b1;
                    end
                    mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE: begin
                        alu_op = (op == mips_isa_pkg::OP_BEQ) ? mips_ctrl_pkg::ALU_EQ
                                                              : mips_ctrl_pkg::ALU_NE;
                        pc_src        = mips_ctrl_pkg::PC_SRC_ALUOUT; // Target from DECODE
                        pc_write_cond = 1'b1;
                    end
                    mips_isa_pkg::OP_J: begin
                        alu_op   = mips_ctrl_pkg::ALU_PASS_B;
                        pc_src   = mips_ctrl_pkg::PC_SRC_JUMP;
                        pc_write = 1'b1;
                    end
                    default: ; // JAL jumps in WRITEBACK while PC still holds the link
                endcase
            end
            mips_ctrl_pkg::WRITEBACK: begin
                reg_write = 1'b1;
                if (op == mips_isa_pkg::OP_JAL) begin
                    wb_sel   = mips_ctrl_pkg::WB_RA;
                    dest_sel = mips_ctrl_pkg::DEST_RA;
                    pc_src   = mips_ctrl_pkg::PC_SRC_JUMP;
                    pc_write = 1'b1;
                end else begin
                    wb_sel = mips_ctrl_pkg::WB_MDR; // Loaded word to rt
                end
            end
            default: ;
        endcase
    end

    // The memory has one port and takes one access per cycle
    assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
        else $error("mem_read and mem_write high together in state %s", state.name());

endmodule

`default_nettype wire

//--- verilog/mips_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu #(
    parameter logic [mips_isa_pkg::WORD_W-1:0] RESET_PC = '0
) (
    input  logic                            clk,
    input  logic                            reset,
    output logic [mips_isa_pkg::WORD_W-1:0] mem_addr,
    output logic [mips_isa_pkg::WORD_W-1:0] mem_wdata,
    input  logic [mips_isa_pkg::WORD_W-1:0] mem_rdata,
    output logic                            mem_read,
    output logic                            mem_write
);

    mips_isa_pkg::opcode_t op;
    mips_isa_pkg::funct_t funct;
    logic ir_write, iord, pc_write, pc_write_cond, reg_write, hilo_write, alu_src_a;
    mips_ctrl_pkg::src_b_t alu_src_b;
    mips_ctrl_pkg::alu_op_t alu_op;
    mips_ctrl_pkg::pc_src_t pc_src;
    mips_ctrl_pkg::wb_sel_t wb_sel;
    mips_ctrl_pkg::dest_sel_t dest_sel;

    mips_control u_control (.*);

    mips_datapath #(.RESET_PC(RESET_PC)) u_datapath (.*);

endmodule

`default_nettype wire

//--- verilog/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE,
        WRITEBACK // Only LW and JAL get here
    } state_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI,
        ALU_PASS_B,
        ALU_MULTU,
        ALU_EQ, // Zero flag carries the branch condition
        ALU_NE
    } alu_op_t;

    typedef enum logic [2:0] {SRC_B_REG, SRC_B_FOUR, SRC_B_SIMM, SRC_B_ZIMM, SRC_B_BRANCH} src_b_t;

    typedef enum logic [1:0] {PC_SRC_ALU, PC_SRC_ALUOUT, PC_SRC_JUMP, PC_SRC_REG_A} pc_src_t;

    typedef enum logic [2:0] {WB_ALU_OUT, WB_MDR, WB_HI, WB_LO, WB_RA} wb_sel_t;

    typedef enum logic [1:0] {DEST_RT, DEST_RD, DEST_RA} dest_sel_t;

endpackage

`default_nettype wire

//--- verilog/mips_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module mips_datapath #(
    parameter logic [mips_isa_pkg::WORD_W-1:0] RESET_PC = '0
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                pc_write,
    input  logic                                pc_write_cond,
    input  mips_ctrl_pkg::pc_src_t              pc_src,
    input  logic                                alu_src_a,
    input  mips_ctrl_pkg::src_b_t               alu_src_b,
    input  mips_ctrl_pkg::alu_op_t              alu_op,
    input  logic                                ir_write,
    input  logic                                iord,
    input  logic                                reg_write,
    input  mips_ctrl_pkg::wb_sel_t              wb_sel,
    input  mips_ctrl_pkg::dest_sel_t            dest_sel,
    input  logic                                hilo_write,
    output mips_isa_pkg::opcode_t               op,
    output mips_isa_pkg::funct_t                funct,
    output logic [mips_isa_pkg::WORD_W-1:0]     mem_addr,
    output logic [mips_isa_pkg::WORD_W-1:0]     mem_wdata,
    input  logic [mips_isa_pkg::WORD_W-1:0]     mem_rdata
);

    localparam int W = mips_isa_pkg::WORD_W;
    localparam int IMM_W = mips_isa_pkg::IMM_W;

    logic [W-1:0] pc, ir, reg_a, reg_b, alu_out, mdr, hi, lo;
    logic [W-1:0] rd1, rd2, src_a, src_b, alu_result, alu_hi, next_pc, wb_data, simm;
    logic [IMM_W-1:0] imm;
    logic [mips_isa_pkg::REG_ADDR_W-1:0] dest;
    logic alu_zero, taken, pc_en;

    assign op    = mips_isa_pkg::opcode_t'(ir[W-1 -: mips_isa_pkg::OPCODE_W]);
    assign funct = mips_isa_pkg::funct_t'(ir[mips_isa_pkg::FUNCT_W-1:0]);
    assign imm   = ir[IMM_W-1:0];
    assign simm  = {{(W-IMM_W){imm[IMM_W-1]}}, imm};

    assign mem_addr  = iord ? alu_result : pc; // Data access uses the live ALU address
    assign mem_wdata = reg_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_en) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_write) ir <= mem_rdata;
        if (iord) mdr <= mem_rdata;
        if (hilo_write) begin
            hi <= alu_hi;
            lo <= alu_result;
        end
        reg_a   <= rd1;
        reg_b   <= rd2;
        alu_out <= alu_result;
    end

    always_comb begin
        src_a = alu_src_a ? reg_a : pc;
        case (alu_src_b)
            mips_ctrl_pkg::SRC_B_FOUR:   src_b = W'(4);
            mips_ctrl_pkg::SRC_B_SIMM:   src_b = simm;
            mips_ctrl_pkg::SRC_B_ZIMM:   src_b = {{(W-IMM_W){1'b0}}, imm};
            mips_ctrl_pkg::SRC_B_BRANCH: src_b = simm << 2; // Word offset to bytes
            default:                     src_b = reg_b;
        endcase
        case (pc_src)
            mips_ctrl_pkg::PC_SRC_ALUOUT: next_pc = alu_out;
            mips_ctrl_pkg::PC_SRC_JUMP:   next_pc = {pc[W-1:W-4], ir[W-7:0], 2'b00};
            mips_ctrl_pkg::PC_SRC_REG_A:  next_pc = reg_a;
            default:                      next_pc = alu_result;
        endcase
        case (wb_sel)
            mips_ctrl_pkg::WB_MDR: wb_data = mdr;
            mips_ctrl_pkg::WB_HI:  wb_data = hi;
            mips_ctrl_pkg::WB_LO:  wb_data = lo;
            mips_ctrl_pkg::WB_RA:  wb_data = pc; // Still address of JAL plus four
            default:               wb_data = alu_result;
        endcase
        case (dest_sel)
            mips_ctrl_pkg::DEST_RD: dest = ir[15:11];
            mips_ctrl_pkg::DEST_RA: dest = {mips_isa_pkg::REG_ADDR_W{1'b1}};
            default:                dest = ir[20:16];
        endcase
    end

    // Only the compare ops may take a branch
    assign taken = alu_zero && (alu_op == mips_ctrl_pkg::ALU_EQ || alu_op == mips_ctrl_pkg::ALU_NE);
    assign pc_en = (pc_write && !pc_write_cond) || (pc_write_cond && taken);

    mips_alu u_alu (
        .a(src_a), .b(src_b), .shamt(ir[10:6]), .op(alu_op),
        .result(alu_result), .hi_result(alu_hi), .zero(alu_zero)
    );

    mips_regfile u_regfile (
        .clk(clk), .reset(reset), .ra1(ir[25:21]), .ra2(ir[20:16]),
        .wa(dest), .wd(wb_data), .we(reg_write), .rd1(rd1), .rd2(rd2)
    );

    // Word-only bus, so every load or store address must be aligned
    assert property (@(posedge clk) disable iff (reset) iord |-> (mem_addr[1:0] == 2'b00))
        else $error("Unaligned data access at %h", mem_addr);

endmodule

`default_nettype wire

//--- verilog/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    localparam int WORD_W     = 32; // Data and address width
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16; // I-type immediate field

    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE = 6'b000000, // Decoded further by funct
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDIU = 6'b001001,
        OP_ORI   = 6'b001101,
        OP_LUI   = 6'b001111,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL   = 6'b000000,
        FN_SRL   = 6'b000010,
        FN_JR    = 6'b001000,
        FN_MFHI  = 6'b010000,
        FN_MFLO  = 6'b010010,
        FN_MULTU = 6'b011001,
        FN_ADDU  = 6'b100001,
        FN_SUBU  = 6'b100011,
        FN_AND   = 6'b100100,
        FN_OR    = 6'b100101,
        FN_XOR   = 6'b100110,
        FN_SLT   = 6'b101010
    } funct_t;

endpackage

`default_nettype wire

//--- verilog/mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] ra1,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] ra2,
    input  logic [mips_isa_pkg::REG_ADDR_W-1:0] wa,
    input  logic [mips_isa_pkg::WORD_W-1:0]     wd,
    input  logic                                we,
    output logic [mips_isa_pkg::WORD_W-1:0]     rd1,
    output logic [mips_isa_pkg::WORD_W-1:0]     rd2
);

    localparam int DEPTH = 2 ** mips_isa_pkg::REG_ADDR_W;

    logic [mips_isa_pkg::WORD_W-1:0] regs [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin // $zero never written
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire
